/* arcade_inputs.f */
+incdir+include
+incdir+tests
hw/input_pkg.sv
hw/board_pkg.sv
hw/joy_4way_filter.sv
hw/player_input_map.sv
hw/board_ctrl.sv
hw/game_reset_gen.sv
hw/arcade_board_top.sv
tests/arcade_board_asserts.sv
tests/tb_arcade_board.sv

/* Makefile */
# Verilator build and run for the arcade board input section

TOP             ?= tb_arcade_board
FILELIST        ?= arcade_inputs.f
BUILD_DIR       ?= obj_dir
SEED_LOG        ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hw/*.sv include/*.svh tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@grep -q "TEST RESULT: PASS" $(SEED_LOG) || (echo "Simulation failed, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

/* tests/tb_arcade_tasks.svh */
`ifndef TB_ARCADE_TASKS_SVH
`define TB_ARCADE_TASKS_SVH

// Low 10 bits of the board word, directions swapped on a rotated screen
function automatic input_pkg::game_joy_t expected_game_joy(input input_pkg::board_joy_t w,
                                                           input logic rot);
    input_pkg::game_joy_t raw;
    raw = w[9:0];
    if (rot) begin
        raw[3] = w[0];
        raw[2] = w[1];
        raw[1] = w[3];
        raw[0] = w[2];
    end
    return {10{ACTIVE_LOW}} ^ raw;
endfunction

function automatic input_pkg::board_joys_t joys_for(input int p, input input_pkg::board_joy_t w);
    input_pkg::board_joys_t j;
    j = '0;
    case (p)
        0:       j.joy1 = w;
        1:       j.joy2 = w;
        2:       j.joy3 = w;
        default: j.joy4 = w;
    endcase
    return j;
endfunction

function automatic input_pkg::game_joy_t game_word(input int p);
    case (p)
        0:       return game_joys.joy1;
        1:       return game_joys.joy2;
        2:       return game_joys.joy3;
        default: return game_joys.joy4;
    endcase
endfunction

// Cycles from the call until game_rst falls, window LEN to LEN+3
task automatic time_game_rst(input string test);
    int cycles;
    bit seen_high;
    cycles    = 0;
    seen_high = game_rst;
    while (!seen_high || game_rst) begin
        wait_cycles(1);
        cycles++;
        if (game_rst) seen_high = 1'b1;
        if (cycles > RST_LEN + 16) begin
            abort_run($sformatf("%s: game_rst did not fall within %0d cycles", test, cycles));
        end
    end
    if (cycles < RST_LEN || cycles > RST_LEN + 3) begin
        abort_run($sformatf("%s: game_rst fell after %0d cycles, allowed %0d to %0d",
                            test, cycles, RST_LEN, RST_LEN + 3));
    end
endtask

task automatic after_reset_state();
    check_value("reset_release game_pause", 0, game_pause);
    check_value("reset_release gfx_en", 4'hf, ctrl.gfx_en);
    check_value("reset_release service", ACTIVE_LOW, ctrl.service);
    check_value("reset_release coin", {4{ACTIVE_LOW}}, ctrl.coin);
    check_value("reset_release start", {4{ACTIVE_LOW}}, ctrl.start);
    check_value("reset_release game_joys", {40{ACTIVE_LOW}}, game_joys);
    time_game_rst("reset_release");
endtask

task automatic joystick_mapping();
    input_pkg::board_joy_t words [4];
    input_pkg::game_joy_t  key_word;
    for (int rot = 0; rot < 2; rot++) begin
        core_mod[0] = rot[0];
        status[2]   = rot[0];
        wait_cycles(1);                // Settings register
        for (int n = 0; n < 8; n++) begin
            for (int p = 0; p < 4; p++) begin
                rng_state = xorshift32(rng_state);
                words[p]  = rng_state[15:0];
            end
            joys = '{joy4: words[3], joy3: words[2], joy2: words[1], joy1: words[0]};
            wait_cycles(3);            // Filter, sync, output
            for (int p = 0; p < 4; p++) begin
                check_value($sformatf("joystick_map rot %0d player %0d", rot, p + 1),
                            expected_game_joy(words[p], rot[0]), game_word(p));
            end
        end
    end
    joys = '0;
    wait_cycles(3);
    // Key word for player 2 goes in at the output register
    rng_state = xorshift32(rng_state);
    key_word  = rng_state[9:0];
    keys.joy2 = key_word;
    wait_cycles(1);
    check_value("joystick_map key player 2", expected_game_joy({6'd0, key_word}, 1'b1),
                game_word(1));
    keys     = '0;
    core_mod = '0;
    status   = '0;
    wait_cycles(2);
endtask

task automatic four_way_step(input string test, input int p,
                             input input_pkg::board_joy_t drive,
                             input input_pkg::board_joy_t expected);
    joys = joys_for(p, drive);
    wait_cycles(3);
    check_value(test, expected_game_joy(expected, 1'b0), game_word(p));
endtask

task automatic four_way_restriction();
    core_mod = 7'b0000010;             // en4way
    wait_cycles(1);
    four_way_step("four_way up", 0, 16'h0011, 16'h0011);
    four_way_step("four_way up right", 0, 16'h0019, 16'h0011);
    four_way_step("four_way down", 2, 16'h0004, 16'h0004);
    four_way_step("four_way down left", 2, 16'h0006, 16'h0004);
    four_way_step("four_way release", 2, 16'h0000, 16'h0000);
    core_mod = '0;
    wait_cycles(2);
endtask

task automatic coin_and_start();
    logic [3:0] one_hot;
    for (int p = 0; p < 4; p++) begin
        one_hot = 4'b0001 << p;
        joys = joys_for(p, 16'(1) << COIN_BIT);
        wait_cycles(2);
        check_value($sformatf("coin_start joy coin p%0d", p + 1),
                    {4{ACTIVE_LOW}} ^ one_hot, ctrl.coin);
        joys = joys_for(p, 16'(1) << START_BIT);
        wait_cycles(2);
        check_value($sformatf("coin_start joy start p%0d", p + 1),
                    {4{ACTIVE_LOW}} ^ one_hot, ctrl.start);
        joys      = '0;
        keys.coin = one_hot;
        wait_cycles(1);
        check_value($sformatf("coin_start key coin p%0d", p + 1),
                    {4{ACTIVE_LOW}} ^ one_hot, ctrl.coin);
        keys.coin  = '0;
        keys.start = one_hot;
        wait_cycles(1);
        check_value($sformatf("coin_start key start p%0d", p + 1),
                    {4{ACTIVE_LOW}} ^ one_hot, ctrl.start);
        keys.start = '0;
        wait_cycles(2);
    end
endtask

task automatic pause_toggling();
    downloading = 1'b1;
    wait_cycles(1);
    check_value("pause download", 0, game_pause);
    keys.pause = 1'b1;                 // Edge while downloading is ignored
    wait_cycles(1);
    check_value("pause key during download", 0, game_pause);
    keys.pause  = 1'b0;
    downloading = 1'b0;
    wait_cycles(1);
    keys.pause = 1'b1;
    wait_cycles(2);
    check_value("pause key press", 1, game_pause);
    keys.pause = 1'b0;
    status[9]  = 1'b1;
    wait_cycles(2);
    check_value("pause osd", 0, game_pause);
    status[9] = 1'b0;
    joys      = joys_for(1, 16'(1) << PAUSE_BIT);
    wait_cycles(2);
    check_value("pause joystick", 1, game_pause);
    joys        = '0;
    downloading = 1'b1;
    wait_cycles(1);
    check_value("pause cleared by download", 0, game_pause);
    downloading = 1'b0;
    wait_cycles(2);
endtask

task automatic gfx_and_service();
    logic [3:0] exp_gfx;
    exp_gfx = 4'hf;
    for (int i = 0; i < 4; i++) begin
        keys.gfx[i] = 1'b1;
        exp_gfx[i]  = ~exp_gfx[i];
        wait_cycles(3);                // Held key toggles once
        check_value($sformatf("gfx key %0d", i), exp_gfx, ctrl.gfx_en);
        keys.gfx[i] = 1'b0;
        wait_cycles(1);
    end
    keys.service = 1'b1;
    wait_cycles(1);
    check_value("service pressed", !ACTIVE_LOW, ctrl.service);
    keys.service = 1'b0;
    wait_cycles(1);
    check_value("service released", ACTIVE_LOW, ctrl.service);
endtask

task automatic game_reset_timing();
    rst_req = 1'b1;
    wait_cycles(1);
    rst_req = 1'b0;
    time_game_rst("game_reset rst_req");
    keys.reset = 1'b1;
    wait_cycles(1);
    keys.reset = 1'b0;
    time_game_rst("game_reset soft key");
    status[3] = 1'b1;
    wait_cycles(1);
    check_value("game_reset flip setting", 1, settings.flip);
    time_game_rst("game_reset flip on");
    status[3] = 1'b0;
    wait_cycles(1);
    time_game_rst("game_reset flip off");
endtask

// Every field of the settings word against the status bit table
task automatic settings_decode();
    board_pkg::board_settings_t exp;
    for (int n = 0; n < 8; n++) begin
        rng_state = xorshift32(rng_state);
        status    = rng_state;
        core_mod  = rng_state[31:25];
        wait_cycles(1);                // Status decode register
        exp.rot_control = status[2] & core_mod[0];
        exp.flip        = status[3];
        exp.test        = status[4];
        exp.fxlevel     = status[6:5];
        exp.enable_fm   = ~status[7];
        exp.enable_psg  = ~status[8];
        exp.osd_pause   = status[9];
        exp.en4way      = core_mod[1];
        check_value($sformatf("settings_decode step %0d", n), exp, settings);
    end
    status   = '0;
    core_mod = '0;
    wait_cycles(1);
endtask

`endif

/* tests/tb_arcade_board.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module tb_arcade_board;

    localparam logic ACTIVE_LOW = `BOARD_INPUTS_ACTIVE_LOW;
    localparam int   RST_LEN    = `BOARD_GAME_RST_LEN;
    localparam int   START_BIT  = 6 + `BOARD_BUTTONS - 2;
    localparam int   COIN_BIT   = 7 + `BOARD_BUTTONS - 2;
    localparam int   PAUSE_BIT  = 8 + `BOARD_BUTTONS - 2;

    logic                       clk_sys;
    logic                       rst;
    logic [6:0]                 core_mod;
    logic [31:0]                status;
    input_pkg::board_joys_t     joys;
    input_pkg::key_state_t      keys;
    logic                       downloading;
    logic                       rst_req;
    logic                       game_rst;
    input_pkg::game_joys_t      game_joys;
    input_pkg::player_ctrl_t    ctrl;
    logic                       game_pause;
    board_pkg::board_settings_t settings;

    logic [31:0] rng_state;

    arcade_board_top uut (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .core_mod    ( core_mod    ),
        .status      ( status      ),
        .joys        ( joys        ),
        .keys        ( keys        ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .game_rst    ( game_rst    ),
        .game_joys   ( game_joys   ),
        .ctrl        ( ctrl        ),
        .game_pause  ( game_pause  ),
        .settings    ( settings    )
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;   // 40 ns period
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                                test, expected, actual));
        end
    endtask

    // Inputs change only on the falling edge
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    `include "tb_arcade_tasks.svh"

    initial begin
        rng_state   = 32'd10015;
        rst         = 1'b1;
        core_mod    = '0;
        status      = '0;
        joys        = '0;
        keys        = '0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        wait_cycles(2);
        rst = 1'b0;

        after_reset_state();
        joystick_mapping();
        four_way_restriction();
        coin_and_start();
        pause_toggling();
        gfx_and_service();
        game_reset_timing();
        settings_decode();

        if (uut.u_asserts.assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            abort_run($sformatf("%0d bound assertion failures were reported",
                                uut.u_asserts.assert_errors));
        end
        $finish;
    end

endmodule

/* tests/arcade_board_asserts.sv */
`timescale 1ns/1ps

module arcade_board_asserts (
    input logic clk_sys,
    input logic rst,
    input logic downloading,
    input logic game_pause,
    input logic game_rst,
    input logic soft_rst
);

    int assert_errors = 0;   // Failures seen so far

    // Game held in reset right after a system reset edge
    a_rst_holds_game: assert property (@(posedge clk_sys) rst |=> game_rst)
        else begin
            assert_errors++;
            $error("game_rst low in the cycle after rst");
        end

    a_pause_download: assert property (@(posedge clk_sys) disable iff (rst)
        downloading |=> !game_pause)
        else begin
            assert_errors++;
            $error("game_pause high while downloading");
        end

    // Soft reset is a single cycle pulse
    a_soft_rst_pulse: assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst)
        else begin
            assert_errors++;
            $error("soft_rst held longer than one cycle");
        end

endmodule

bind arcade_board_top arcade_board_asserts u_asserts (
    .clk_sys     ( clk_sys     ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .game_pause  ( game_pause  ),
    .game_rst    ( game_rst    ),
    .soft_rst    ( soft_rst    )
);

/* hw/arcade_board_top.sv */
`timescale 1ns/1ps

module arcade_board_top (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic [6:0]                 core_mod,
    input  logic [31:0]                status,
    input  input_pkg::board_joys_t     joys,
    input  input_pkg::key_state_t      keys,
    input  logic                       downloading,
    input  logic                       rst_req,
    output logic                       game_rst,
    output input_pkg::game_joys_t      game_joys,
    output input_pkg::player_ctrl_t    ctrl,
    output logic                       game_pause,
    output board_pkg::board_settings_t settings
);

    logic       joy_pause;
    logic       soft_rst;
    logic       service;
    logic [3:0] gfx_en;
    logic [3:0] coin;
    logic [3:0] start;

    // Gather the game controls into one word
    assign ctrl = '{coin: coin, start: start, service: service, gfx_en: gfx_en};

    player_input_map u_input_map (
        .clk_sys     ( clk_sys              ),
        .rst         ( rst                  ),
        .joys        ( joys                 ),
        .keys        ( keys                 ),
        .en4way      ( settings.en4way      ),
        .rot_control ( settings.rot_control ),
        .game_joys   ( game_joys            ),
        .coin        ( coin                 ),
        .start       ( start                ),
        .joy_pause   ( joy_pause            )
    );

    board_ctrl u_board_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .status      ( status      ),
        .core_mod    ( core_mod    ),
        .keys        ( keys        ),
        .joy_pause   ( joy_pause   ),
        .downloading ( downloading ),
        .settings    ( settings    ),
        .game_pause  ( game_pause  ),
        .service     ( service     ),
        .gfx_en      ( gfx_en      ),
        .soft_rst    ( soft_rst    )
    );

    game_reset_gen u_game_rst (
        .clk_sys     ( clk_sys       ),
        .rst         ( rst           ),
        .downloading ( downloading   ),
        .rst_req     ( rst_req       ),
        .soft_rst    ( soft_rst      ),
        .flip        ( settings.flip ),
        .game_rst    ( game_rst      )
    );

endmodule

/* hw/game_reset_gen.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module game_reset_gen (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic game_rst
);

    localparam int            LEN     = `BOARD_GAME_RST_LEN;
    localparam int            CW      = $clog2(LEN + 1);
    localparam logic [CW-1:0] CNT_END = LEN[CW-1:0];

    logic [CW-1:0] cnt;
    logic          flip_q;
    logic          flip_chg;   // One cycle after any flip change
    logic          cause;

    assign cause = rst | downloading | rst_req | soft_rst | flip_chg;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            flip_q   <= flip;
            flip_chg <= 1'b0;
        end else begin
            flip_q   <= flip;
            flip_chg <= flip_q != flip;
        end
    end

    // Counter restarts on every cause and saturates at the end value
    always_ff @(posedge clk_sys) begin
        if (cause) begin
            cnt      <= '0;
            game_rst <= 1'b1;
        end else if (cnt != CNT_END) begin
            cnt      <= cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

endmodule

/* hw/board_ctrl.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module board_ctrl (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic [31:0]                status,
    input  logic [6:0]                 core_mod,
    input  input_pkg::key_state_t      keys,
    input  logic                       joy_pause,
    input  logic                       downloading,
    output board_pkg::board_settings_t settings,
    output logic                       game_pause,
    output logic                       service,
    output logic [3:0]                 gfx_en,
    output logic                       soft_rst
);

    localparam logic INV = `BOARD_INPUTS_ACTIVE_LOW;

    logic       last_key_pause;
    logic       last_joy_pause;
    logic       last_osd_pause;
    logic       last_reset;
    logic [3:0] last_gfx;
    logic       pause_edge;
    logic [3:0] gfx_edge;

    // Any of the three pause sources toggles
    assign pause_edge = (keys.pause & ~last_key_pause) |
                        (joy_pause & ~last_joy_pause) |
                        (settings.osd_pause & ~last_osd_pause);

    assign gfx_edge = keys.gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings <= '0;
        end else begin
            settings <= '{
                rot_control: status[2] & core_mod[0],
                flip:        status[3],
                test:        status[4],
                fxlevel:     status[6:5],
                enable_fm:   ~status[7],   // Sound chips on by default
                enable_psg:  ~status[8],
                osd_pause:   status[9],
                en4way:      core_mod[1]
            };
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_reset     <= 1'b0;
            last_gfx       <= 4'd0;
            game_pause     <= 1'b0;
            service        <= INV;       // Inactive level
            gfx_en         <= 4'hf;      // All layers shown
            soft_rst       <= 1'b0;
        end else begin
            last_key_pause <= keys.pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= settings.osd_pause;
            last_reset     <= keys.reset;
            last_gfx       <= keys.gfx;

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end

            gfx_en   <= gfx_en ^ gfx_edge;
            service  <= keys.service ^ INV;
            soft_rst <= keys.reset & ~last_reset;   // Single cycle pulse
        end
    end

endmodule

/* hw/player_input_map.sv */
`timescale 1ns/1ps
`include "board_cfg.svh"

module player_input_map (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  input_pkg::board_joys_t joys,
    input  input_pkg::key_state_t  keys,
    input  logic                  en4way,
    input  logic                  rot_control,
    output input_pkg::game_joys_t  game_joys,
    output logic [3:0]            coin,
    output logic [3:0]            start,
    output logic                  joy_pause
);

    localparam int   START_BIT = 6 + `BOARD_BUTTONS - 2;
    localparam int   COIN_BIT  = 7 + `BOARD_BUTTONS - 2;
    localparam int   PAUSE_BIT = 8 + `BOARD_BUTTONS - 2;
    localparam logic INV       = `BOARD_INPUTS_ACTIVE_LOW;

    input_pkg::board_joy_t joy_in   [4];
    input_pkg::board_joy_t joy_sync [4];
    input_pkg::game_joy_t  key_joy  [4];
    input_pkg::game_joy_t  joy_q    [4];
    logic [3:0]            dir4     [4];
    logic [3:0]            coin_joy;
    logic [3:0]            start_joy;

    // Swap directions for games on a rotated screen
    function automatic input_pkg::game_joy_t rotate_dirs(
        input input_pkg::game_joy_t j,
        input logic                 rot
    );
        rotate_dirs = rot ? {j[9:4], j[0], j[1], j[3], j[2]} : j;
    endfunction

    assign joy_in[0] = joys.joy1;
    assign joy_in[1] = joys.joy2;
    assign joy_in[2] = joys.joy3;
    assign joy_in[3] = joys.joy4;

    assign key_joy[0] = keys.joy1;
    assign key_joy[1] = keys.joy2;
    assign key_joy[2] = keys.joy3;
    assign key_joy[3] = '0;         // No keyboard map for player 4

    for (genvar i = 0; i < 4; i++) begin : g_player
        joy_4way_filter u_filter (
            .clk_sys ( clk_sys         ),
            .rst     ( rst             ),
            .enable  ( en4way          ),
            .joy8    ( joy_in[i][3:0]  ),
            .joy4    ( dir4[i]         )
        );
    end

    // Sync stage, directions arrive one cycle behind the buttons
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) joy_sync[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) joy_sync[i] <= {joy_in[i][15:4], dir4[i]};
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            coin_joy[i]  = joy_sync[i][COIN_BIT];
            start_joy[i] = joy_sync[i][START_BIT];
        end
    end

    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) joy_q[i] <= {10{INV}};
            coin  <= {4{INV}};
            start <= {4{INV}};
        end else begin
            for (int i = 0; i < 4; i++) begin
                joy_q[i] <= {10{INV}} ^ rotate_dirs(joy_sync[i][9:0] | key_joy[i], rot_control);
            end
            coin  <= {4{INV}} ^ (coin_joy | keys.coin);
            start <= {4{INV}} ^ (start_joy | keys.start);
        end
    end

    assign game_joys = '{joy4: joy_q[3], joy3: joy_q[2], joy2: joy_q[1], joy1: joy_q[0]};

endmodule

/* hw/joy_4way_filter.sv */
`timescale 1ns/1ps

module joy_4way_filter (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] joy8,
    output logic [3:0] joy4
);

    logic [3:0] last_dir;   // Last single direction seen
    logic       single;

    // Exactly one of right, left, down, up
    assign single = (joy8 == 4'b0001) || (joy8 == 4'b0010) ||
                    (joy8 == 4'b0100) || (joy8 == 4'b1000);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= 4'd0;
            joy4     <= 4'd0;
        end else if (!enable) begin
            joy4     <= joy8;       // Plain register stage
        end else if (single) begin
            last_dir <= joy8;
            joy4     <= joy8;
        end else if (joy8 == 4'd0) begin
            // Stick released, forget the held direction
            last_dir <= 4'd0;
            joy4     <= 4'd0;
        end else begin
            joy4     <= last_dir;   // Diagonal keeps the earlier direction
        end
    end

endmodule

/* hw/board_pkg.sv */
package board_pkg;

    // Board settings decoded from the OSD status word and core_mod
    //
    // status[2] & core_mod[0]  rot_control
    // status[3]                flip
    // status[4]                test
    // status[6:5]              fxlevel
    // status[7] low            enable_fm
    // status[8] low            enable_psg
    // status[9]                osd_pause
    // core_mod[1]              en4way
    typedef struct packed {
        logic       rot_control;  // Rotate joystick directions
        logic       flip;         // Screen flip dip
        logic       test;         // Test mode dip
        logic [1:0] fxlevel;
        logic       enable_fm;
        logic       enable_psg;
        logic       osd_pause;    // Pause request from the OSD
        logic       en4way;       // Restrict joysticks to 4 directions
    } board_settings_t;

endpackage

/* hw/input_pkg.sv */
package input_pkg;

    // Board joystick word
    // [3:0] right, left, down, up
    // [15:4] buttons, then start, coin and pause
    typedef logic [15:0] board_joy_t;

    // Joystick word as the game core sees it
    typedef logic [9:0] game_joy_t;

    // One board joystick per player
    typedef struct packed {
        board_joy_t joy4;
        board_joy_t joy3;
        board_joy_t joy2;
        board_joy_t joy1;
    } board_joys_t;

    typedef struct packed {
        game_joy_t joy4;
        game_joy_t joy3;
        game_joy_t joy2;
        game_joy_t joy1;
    } game_joys_t;

    // Keys as delivered by the keyboard decoder, active high
    typedef struct packed {
        game_joy_t  joy1;
        game_joy_t  joy2;
        game_joy_t  joy3;
        logic [3:0] start;
        logic [3:0] coin;
        logic       reset;    // Soft reset key
        logic       pause;
        logic       service;
        logic [3:0] gfx;      // Layer toggle keys
    } key_state_t;

    // Controls sent to the game, polarity already applied
    typedef struct packed {
        logic [3:0] coin;
        logic [3:0] start;
        logic       service;
        logic [3:0] gfx_en;
    } player_ctrl_t;

endpackage

/* include/board_cfg.svh */
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Game buttons per player, start/coin/pause sit right above them
`define BOARD_BUTTONS 2

// 1 when the game core reads its controls inverted
`define BOARD_INPUTS_ACTIVE_LOW 1

// Game reset stretch after the last cause, in clk_sys cycles
`define BOARD_GAME_RST_LEN 255

`endif
